// File: Makefile
# Verilator build, run, lint and clean for the DMA front end

TOP = tb_dma_wrap

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert --timescale 1ns/1ps \
	  -f files.f --top-module $(TOP) -Mdir obj_dir

run: build
	./obj_dir/V$(TOP) > sim.log 2>&1; status=$$?; cat sim.log; \
	if [ $$status -ne 0 ] || grep -q "ERRORS FOUND" sim.log || \
	   ! grep -q "NO ERRORS" sim.log; then \
	  echo "simulation failed"; exit 1; \
	fi

lint:
	verilator --lint-only --timing --assert --timescale 1ns/1ps \
	  -f files.f --top-module $(TOP)

clean:
	rm -rf obj_dir sim.log

// File: files.f
verilog/dma_pkg.sv
verilog/dma_reg_frontend.sv
verilog/dma_req_queue.sv
verilog/dma_2d_midend.sv
verilog/dma_wrap.sv
verif/dma_wrap_checker.sv
verif/tb_dma_wrap.sv

// File: verif/dma_wrap_checker.sv
//--------------------------------------------------------------------------
// concurrent assertions on the DMA top-level ports, bound into dma_wrap
//--------------------------------------------------------------------------

`timescale 1ns/1ps
`default_nettype none

module dma_wrap_checker (
  input logic                clk_i,
  input logic                rst_n_i,
  input dma_pkg::cfg_req_t   cfg_req_i,
  input dma_pkg::cfg_rsp_t   cfg_rsp_o,
  input dma_pkg::burst_req_t burst_o,
  input logic                burst_valid_o,
  input logic                burst_ready_i,
  input logic                term_event_o,
  input logic                busy_o
);

  // response exactly one cycle after a granted request, never otherwise
  a_rvalid_after_gnt: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    (cfg_req_i.req && cfg_rsp_o.gnt) |=> cfg_rsp_o.r_valid)
    else $error("r_valid missing one cycle after a granted request");

  a_no_rvalid_without_gnt: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    !(cfg_req_i.req && cfg_rsp_o.gnt) |=> !cfg_rsp_o.r_valid)
    else $error("r_valid without a granted request");

  // burst held while the backend stalls
  a_burst_stable: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    (burst_valid_o && !burst_ready_i) |=> (burst_valid_o && $stable(burst_o)))
    else $error("burst changed or dropped while ready was low");

  a_term_single: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    term_event_o |=> !term_event_o)
    else $error("term_event_o lasted two cycles");

  // first cycle out of reset
  a_reset_quiet: assert property (@(posedge clk_i)
    $rose(rst_n_i) |-> (!burst_valid_o && !term_event_o && !busy_o))
    else $error("outputs not low after reset");

endmodule

bind dma_wrap dma_wrap_checker i_checker (
  .clk_i         (clk_i),
  .rst_n_i       (rst_n_i),
  .cfg_req_i     (cfg_req_i),
  .cfg_rsp_o     (cfg_rsp_o),
  .burst_o       (burst_o),
  .burst_valid_o (burst_valid_o),
  .burst_ready_i (burst_ready_i),
  .term_event_o  (term_event_o),
  .busy_o        (busy_o)
);

`default_nettype wire

// File: verif/tb_dma_wrap.sv
//--------------------------------------------------------------------------
// testbench for the DMA front end: programs transfers over the control
// port, models the burst backend and checks bursts, IDs and events
//--------------------------------------------------------------------------

`timescale 1ns/1ps
`default_nettype none

module tb_dma_wrap;

  localparam int unsigned QueueDepth  = 2;
  localparam int          ClkPeriod   = 100;
  localparam int          DriveDelay  = 10;
  localparam int          SampleDelay = 20;
  localparam int unsigned Seed        = 32'hb025_085e;

  logic                clk_i;
  logic                rst_n_i;
  dma_pkg::cfg_req_t   cfg_req;
  dma_pkg::cfg_rsp_t   cfg_rsp;
  dma_pkg::burst_req_t burst;
  logic                burst_valid, burst_ready, burst_rsp_valid;
  logic                term_event, busy;

  // reference model and scoreboard state
  dma_pkg::data_t      cfg_model [6] = '{default: '0};
  dma_pkg::burst_req_t exp_bursts [$];
  int                  exp_cum [$];
  dma_pkg::tf_id_t     exp_next_id = 32'd1;
  int                  launched = 0, done_cnt = 0, rsp_sent = 0, accepted = 0;
  int                  cum_bursts = 0;
  int                  tests = 0, checks = 0, errors = 0, test_errors = 0;
  logic                hold_ready = 1'b0;
  string               cur_test = "reset";

  dma_wrap #(
    .QueueDepth (QueueDepth)
  ) uut (
    .clk_i             (clk_i),
    .rst_n_i           (rst_n_i),
    .cfg_req_i         (cfg_req),
    .cfg_rsp_o         (cfg_rsp),
    .burst_o           (burst),
    .burst_valid_o     (burst_valid),
    .burst_ready_i     (burst_ready),
    .burst_rsp_valid_i (burst_rsp_valid),
    .term_event_o      (term_event),
    .busy_o            (busy)
  );

  initial begin : clock_gen
    clk_i = 1'b0;
    forever #(ClkPeriod / 2) clk_i = ~clk_i;
  end

  task automatic check_value(input string what, input logic [31:0] exp_val,
                             input logic [31:0] act_val);
    checks++;
    assert (act_val === exp_val) else begin
      $display("** Error %s: %s expected %h actual %h", cur_test, what, exp_val, act_val);
      errors++;
    end
  endtask

  task automatic report_problem(input string msg);
    $display("%s: %s", cur_test, msg);
    errors++;
  endtask

  task automatic start_test(input string name);
    cur_test    = name;
    test_errors = errors;
  endtask

  task automatic end_test();
    tests++;
    $display("test %-16s %s", cur_test, (errors == test_errors) ? "passed" : "failed");
  endtask

  task automatic finish_run();
    $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
    if (errors == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  endtask

  // expected bursts of a launch, from the current register model
  task automatic record_launch();
    int                  n;
    dma_pkg::burst_req_t b;
    n = (cfg_model[5] == '0) ? 1 : int'(cfg_model[5]);
    for (int k = 0; k < n; k++) begin
      b.src = cfg_model[0] + dma_pkg::addr_t'(k) * cfg_model[3];
      b.dst = cfg_model[1] + dma_pkg::addr_t'(k) * cfg_model[4];
      b.len = cfg_model[2];
      exp_bursts.push_back(b);
    end
    cum_bursts += n;
    exp_cum.push_back(cum_bursts);
    launched++;
  endtask

  //--------------------------------------------------------------------------
  // control port access, entered and left just after a rising edge
  //--------------------------------------------------------------------------
  task automatic cfg_access(input logic we, input logic [7:0] off,
                            input dma_pkg::data_t wdata, input dma_pkg::be_t be,
                            input int max_wait, output dma_pkg::data_t rdata,
                            output logic granted);
    int waited;
    waited        = 0;
    rdata         = '0;
    cfg_req.req   = 1'b1;
    cfg_req.we    = we;
    cfg_req.addr  = {24'h0, off};
    cfg_req.wdata = wdata;
    cfg_req.be    = be;
    #(SampleDelay - DriveDelay);
    while (!cfg_rsp.gnt && waited < max_wait) begin
      @(posedge clk_i);
      #(SampleDelay);
      waited++;
    end
    granted = cfg_rsp.gnt;
    if (granted && !we && off == dma_pkg::RegNextId) begin
      record_launch();
    end
    @(posedge clk_i);
    #(DriveDelay);
    cfg_req.req = 1'b0;
    if (granted) begin
      if (!cfg_rsp.r_valid) begin
        report_problem("no response one cycle after the grant");
      end
      rdata = cfg_rsp.r_data;
    end
  endtask

  task automatic write_reg(input logic [7:0] off, input dma_pkg::data_t value,
                           input dma_pkg::be_t be);
    dma_pkg::data_t rdata;
    logic           granted;
    int             idx;
    cfg_access(1'b1, off, value, be, 5, rdata, granted);
    idx = int'(off) / 4;
    if (!granted) begin
      report_problem("register write was not granted");
    end else begin
      for (int b = 0; b < 4; b++) begin
        if (be[b]) begin
          cfg_model[idx][8*b +: 8] = value[8*b +: 8];
        end
      end
      check_value("write response data", 32'h0, rdata);
    end
  endtask

  task automatic read_expect(input string what, input logic [7:0] off,
                             input dma_pkg::data_t exp_val);
    dma_pkg::data_t rdata;
    logic           granted;
    cfg_access(1'b0, off, '0, 4'hf, 5, rdata, granted);
    if (!granted) begin
      report_problem("register read was not granted");
    end else begin
      check_value(what, exp_val, rdata);
    end
  endtask

  task automatic program_transfer(input dma_pkg::addr_t src, input dma_pkg::addr_t dst,
                                  input dma_pkg::len_t len, input dma_pkg::stride_t ss,
                                  input dma_pkg::stride_t ds, input dma_pkg::reps_t reps);
    write_reg(dma_pkg::RegSrcAddr, src, 4'hf);
    write_reg(dma_pkg::RegDstAddr, dst, 4'hf);
    write_reg(dma_pkg::RegLength, len, 4'hf);
    write_reg(dma_pkg::RegSrcStride, ss, 4'hf);
    write_reg(dma_pkg::RegDstStride, ds, 4'hf);
    write_reg(dma_pkg::RegReps, reps, 4'hf);
  endtask

  task automatic launch_expect(input int max_wait);
    dma_pkg::data_t id;
    logic           granted;
    cfg_access(1'b0, dma_pkg::RegNextId, '0, 4'hf, max_wait, id, granted);
    if (!granted) begin
      report_problem("launch was not granted");
    end else begin
      check_value("launch id", exp_next_id, id);
      exp_next_id++;
    end
  endtask

  task automatic wait_for_completions(input int target, input int max_cycles);
    int cycles;
    cycles = 0;
    #(SampleDelay - DriveDelay);
    while (done_cnt < target && cycles < max_cycles) begin
      @(posedge clk_i);
      #(SampleDelay);
      cycles++;
    end
    if (done_cnt < target) begin
      report_problem("timed out waiting for transfers to complete");
    end
    @(posedge clk_i);
    #(DriveDelay);
  endtask

  task automatic set_hold_ready(input logic value);
    #(SampleDelay - DriveDelay);
    hold_ready = value;
    @(posedge clk_i);
    #(DriveDelay);
  endtask

  //--------------------------------------------------------------------------
  // backend model and burst scoreboard
  //--------------------------------------------------------------------------
  initial begin : backend_model
    dma_pkg::burst_req_t exp_b;
    int                  pending;
    logic                active;
    pending         = 0;
    burst_ready     = 1'b0;
    burst_rsp_valid = 1'b0;
    forever begin
      @(posedge clk_i);
      // reset is sampled at the edge, where it is stable
      active = rst_n_i;
      #(DriveDelay);
      if (active) begin
        // event follows the response that completed the transfer
        if (term_event) begin
          done_cnt++;
          if (exp_cum.size() == 0) begin
            report_problem("completion event without a launched transfer");
          end else begin
            check_value("responses before completion", exp_cum.pop_front(), rsp_sent);
          end
        end
        check_value("busy flag", 32'(launched != done_cnt), 32'(busy));
        if (pending > 0 && ($urandom() % 4) != 0) begin
          burst_rsp_valid = 1'b1;
          pending--;
          rsp_sent++;
        end else begin
          burst_rsp_valid = 1'b0;
        end
        burst_ready = ~hold_ready & (($urandom() % 2) == 1);
        if (burst_valid && burst_ready) begin
          accepted++;
          pending++;
          if (exp_bursts.size() == 0) begin
            report_problem("burst issued without a launched transfer");
          end else begin
            exp_b = exp_bursts.pop_front();
            check_value("burst src", exp_b.src, burst.src);
            check_value("burst dst", exp_b.dst, burst.dst);
            check_value("burst len", exp_b.len, burst.len);
          end
        end
      end
    end
  end

  //--------------------------------------------------------------------------
  // test sequence
  //--------------------------------------------------------------------------
  initial begin : main_sequence
    dma_pkg::data_t id;
    logic           granted;
    void'($urandom(Seed));
    cfg_req = '0;
    rst_n_i = 1'b0;
    repeat (5) @(posedge clk_i);
    #(DriveDelay);
    rst_n_i = 1'b1;

    start_test("register_readback");
    read_expect("done id after reset", dma_pkg::RegDoneId, 32'h0);
    read_expect("status after reset", dma_pkg::RegStatus, 32'h0);
    // full words first, then partial byte enables
    for (int round = 0; round < 2; round++) begin
      for (int r = 0; r < 6; r++) begin
        write_reg(8'(4 * r), $urandom(), (round == 0) ? 4'hf : 4'($urandom()));
      end
      for (int r = 0; r < 6; r++) begin
        read_expect("config register", 8'(4 * r), cfg_model[r]);
      end
    end
    end_test();

    start_test("single_burst");
    program_transfer(32'h1000_0000, 32'h2000_0040, 32'd64, 32'h0, 32'h0, 32'd1);
    launch_expect(20);
    wait_for_completions(1, 200);
    check_value("bursts left", 32'h0, exp_bursts.size());
    read_expect("done id", dma_pkg::RegDoneId, 32'd1);
    end_test();

    start_test("burst_2d");
    program_transfer(32'h3000_0000 | ($urandom() & 32'h00ff_ff00), 32'h4000_0000,
                     32'd32, 32'h100, 32'h40, 32'd4);
    launch_expect(20);
    wait_for_completions(2, 400);
    check_value("bursts accepted", 32'd5, accepted);
    check_value("bursts left", 32'h0, exp_bursts.size());
    read_expect("done id", dma_pkg::RegDoneId, 32'd2);
    end_test();

    start_test("back_pressure");
    set_hold_ready(1'b1);
    // one transfer in the midend, QueueDepth more in the queue
    for (int t = 0; t <= int'(QueueDepth); t++) begin
      program_transfer(32'h5000_0000 + 32'(t) * 32'h1000, 32'h6000_0000 + 32'(t) * 32'h1000,
                       32'd16, 32'h20, 32'h80, 32'd2);
      launch_expect(20);
    end
    cfg_access(1'b0, dma_pkg::RegNextId, '0, 4'hf, 8, id, granted);
    if (granted) begin
      report_problem("launch granted while the midend and queue were full");
    end
    set_hold_ready(1'b0);
    wait_for_completions(launched, 600);
    check_value("bursts left", 32'h0, exp_bursts.size());
    read_expect("done id", dma_pkg::RegDoneId, exp_next_id - 32'd1);
    end_test();

    start_test("busy_flag");
    check_value("busy when idle", 32'h0, 32'(busy));
    set_hold_ready(1'b1);
    program_transfer(32'h7000_0000, 32'h7800_0000, 32'd8, 32'h10, 32'h10, 32'd3);
    launch_expect(20);
    read_expect("status after launch", dma_pkg::RegStatus, 32'h1);
    check_value("busy after launch", 32'h1, 32'(busy));
    set_hold_ready(1'b0);
    wait_for_completions(launched, 400);
    check_value("busy after completion", 32'h0, 32'(busy));
    read_expect("status after completion", dma_pkg::RegStatus, 32'h0);
    end_test();

    finish_run();
  end

endmodule

`default_nettype wire

// File: verilog/dma_2d_midend.sv
//--------------------------------------------------------------------------
// 2D midend: takes one queued transfer, issues one burst per repetition
// with strided addresses and counts backend responses up to completion
//--------------------------------------------------------------------------

`timescale 1ns/1ps
`default_nettype none

module dma_2d_midend (
  input  logic                clk_i,
  input  logic                rst_n_i,
  input  logic                nd_valid_i,
  input  dma_pkg::nd_req_t    nd_req_i,
  output logic                nd_ready_o,
  output dma_pkg::burst_req_t burst_o,
  output logic                burst_valid_o,
  input  logic                burst_ready_i,
  input  logic                burst_rsp_valid_i,
  output logic                trans_done_o,
  output logic                idle_o
);

  dma_pkg::midend_state_e state_q, state_d;
  dma_pkg::addr_t         src_q, dst_q;
  dma_pkg::len_t          len_q;
  dma_pkg::stride_t       src_stride_q, dst_stride_q;
  dma_pkg::reps_t         total_q, issued_q, rsp_cnt_q;
  logic                   take, burst_fire, last_burst, rsp_counted;

  assign idle_o        = (state_q == dma_pkg::MidIdle);
  assign nd_ready_o    = idle_o;
  assign take          = nd_valid_i & nd_ready_o;
  assign burst_valid_o = (state_q == dma_pkg::MidIssue);
  assign burst_fire    = burst_valid_o & burst_ready_i;
  assign last_burst    = burst_fire & ((issued_q + dma_pkg::reps_t'(1)) == total_q);

  // responses count in issue as well as in wait_rsp
  assign rsp_counted   = burst_rsp_valid_i & ~idle_o;
  assign trans_done_o  = rsp_counted & ((rsp_cnt_q + dma_pkg::reps_t'(1)) == total_q);

  always_comb begin
    burst_o.src = src_q;
    burst_o.dst = dst_q;
    burst_o.len = len_q;
  end

  //--------------------------------------------------------------------------
  // FSM
  //--------------------------------------------------------------------------
  always_comb begin
    state_d = state_q;
    case (state_q)
      dma_pkg::MidIdle: begin
        if (nd_valid_i) begin
          state_d = dma_pkg::MidIssue;
        end
      end
      dma_pkg::MidIssue: begin
        if (last_burst) begin
          state_d = dma_pkg::MidWaitRsp;
        end
      end
      dma_pkg::MidWaitRsp: ;
      default: state_d = dma_pkg::MidIdle;
    endcase
    // the last response closes the transfer
    if (trans_done_o) begin
      state_d = dma_pkg::MidIdle;
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      state_q   <= dma_pkg::MidIdle;
      issued_q  <= '0;
      rsp_cnt_q <= '0;
    end else begin
      state_q <= state_d;
      if (take) begin
        issued_q  <= '0;
        rsp_cnt_q <= '0;
      end else begin
        if (burst_fire) begin
          issued_q <= issued_q + dma_pkg::reps_t'(1);
        end
        if (rsp_counted) begin
          rsp_cnt_q <= rsp_cnt_q + dma_pkg::reps_t'(1);
        end
      end
    end
  end

  //--------------------------------------------------------------------------
  // burst addresses
  //--------------------------------------------------------------------------
  always_ff @(posedge clk_i) begin
    if (take) begin
      src_q        <= nd_req_i.burst.src;
      dst_q        <= nd_req_i.burst.dst;
      len_q        <= nd_req_i.burst.len;
      src_stride_q <= nd_req_i.src_stride;
      dst_stride_q <= nd_req_i.dst_stride;
      // reps of zero still means one burst
      total_q      <= (nd_req_i.reps == '0) ? dma_pkg::reps_t'(1) : nd_req_i.reps;
    end else if (burst_fire) begin
      src_q <= src_q + src_stride_q;
      dst_q <= dst_q + dst_stride_q;
    end
  end

endmodule

`default_nettype wire

// File: verilog/dma_pkg.sv
//--------------------------------------------------------------------------
// shared types for the DMA front end: register map, request structs and
// midend states, referenced by scoped names from every RTL module
//--------------------------------------------------------------------------

`default_nettype none

package dma_pkg;

  // basic word types, all 32 bits wide
  typedef logic [31:0] addr_t;
  typedef logic [31:0] len_t;
  typedef logic [31:0] reps_t;
  typedef logic [31:0] stride_t;
  typedef logic [31:0] tf_id_t;
  typedef logic [31:0] data_t;
  typedef logic [$bits(data_t)/8-1:0] be_t;

  // only the low bits of the control-port address are decoded
  localparam int unsigned RegAddrWidth = 8;

  // word-aligned register offsets
  typedef enum logic [RegAddrWidth-1:0] {
    RegSrcAddr   = 8'h00,
    RegDstAddr   = 8'h04,
    RegLength    = 8'h08,
    RegSrcStride = 8'h0C,
    RegDstStride = 8'h10,
    RegReps      = 8'h14,
    RegNextId    = 8'h18,
    RegDoneId    = 8'h1C,
    RegStatus    = 8'h20
  } reg_off_e;

  // control port, request direction
  typedef struct packed {
    logic  req;
    logic  we;
    addr_t addr;
    data_t wdata;
    be_t   be;
  } cfg_req_t;

  // control port, response direction
  typedef struct packed {
    logic  gnt;
    logic  r_valid;
    data_t r_data;
  } cfg_rsp_t;

  // one burst handed to the backend
  typedef struct packed {
    addr_t src;
    addr_t dst;
    len_t  len;
  } burst_req_t;

  // one launched 2D transfer
  typedef struct packed {
    burst_req_t burst;
    reps_t      reps;
    stride_t    src_stride;
    stride_t    dst_stride;
  } nd_req_t;

  typedef enum logic [1:0] {
    MidIdle,
    MidIssue,
    MidWaitRsp
  } midend_state_e;

endpackage

`default_nettype wire

// File: verilog/dma_reg_frontend.sv
//--------------------------------------------------------------------------
// control-port register file of the DMA; reading next ID launches the
// programmed transfer into the request queue and returns its ID
//--------------------------------------------------------------------------

`timescale 1ns/1ps
`default_nettype none

module dma_reg_frontend (
  input  logic              clk_i,
  input  logic              rst_n_i,
  input  dma_pkg::cfg_req_t cfg_req_i,
  output dma_pkg::cfg_rsp_t cfg_rsp_o,
  input  logic              busy_i,
  input  logic              trans_done_i,
  output logic              launch_valid_o,
  output dma_pkg::nd_req_t  launch_req_o,
  input  logic              launch_ready_i
);

  // merge a write word into a register under byte enables
  function automatic dma_pkg::data_t merge_be(input dma_pkg::data_t old_val,
                                              input dma_pkg::data_t new_val,
                                              input dma_pkg::be_t   be);
    dma_pkg::data_t res;
    res = old_val;
    for (int b = 0; b < $bits(dma_pkg::be_t); b++) begin
      if (be[b]) begin
        res[8*b +: 8] = new_val[8*b +: 8];
      end
    end
    return res;
  endfunction

  dma_pkg::reg_off_e reg_off;
  dma_pkg::addr_t    src_q, dst_q;
  dma_pkg::len_t     len_q;
  dma_pkg::stride_t  src_stride_q, dst_stride_q;
  dma_pkg::reps_t    reps_q;
  dma_pkg::tf_id_t   next_id_q, done_id_q;
  dma_pkg::data_t    rdata, r_data_q;
  logic              is_launch, gnt, wr_en, r_valid_q;

  assign reg_off = dma_pkg::reg_off_e'(cfg_req_i.addr[dma_pkg::RegAddrWidth-1:0]);

  // a launch is a read of next ID; refuse it while the queue is full
  assign is_launch      = cfg_req_i.req & ~cfg_req_i.we & (reg_off == dma_pkg::RegNextId);
  assign gnt            = cfg_req_i.req & (~is_launch | launch_ready_i);
  assign wr_en          = cfg_req_i.req & cfg_req_i.we;
  assign launch_valid_o = is_launch;

  always_comb begin
    launch_req_o.burst.src  = src_q;
    launch_req_o.burst.dst  = dst_q;
    launch_req_o.burst.len  = len_q;
    launch_req_o.reps       = reps_q;
    launch_req_o.src_stride = src_stride_q;
    launch_req_o.dst_stride = dst_stride_q;
  end

  //--------------------------------------------------------------------------
  // configuration registers
  //--------------------------------------------------------------------------
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      src_q        <= '0;
      dst_q        <= '0;
      len_q        <= '0;
      src_stride_q <= '0;
      dst_stride_q <= '0;
      reps_q       <= '0;
    end else if (wr_en) begin
      case (reg_off)
        dma_pkg::RegSrcAddr:   src_q        <= merge_be(src_q, cfg_req_i.wdata, cfg_req_i.be);
        dma_pkg::RegDstAddr:   dst_q        <= merge_be(dst_q, cfg_req_i.wdata, cfg_req_i.be);
        dma_pkg::RegLength:    len_q        <= merge_be(len_q, cfg_req_i.wdata, cfg_req_i.be);
        dma_pkg::RegSrcStride: begin
          src_stride_q <= merge_be(src_stride_q, cfg_req_i.wdata, cfg_req_i.be);
        end
        dma_pkg::RegDstStride: begin
          dst_stride_q <= merge_be(dst_stride_q, cfg_req_i.wdata, cfg_req_i.be);
        end
        dma_pkg::RegReps:      reps_q       <= merge_be(reps_q, cfg_req_i.wdata, cfg_req_i.be);
        // ID and status registers are read only
        default: ;
      endcase
    end
  end

  //--------------------------------------------------------------------------
  // transfer ID counters
  //--------------------------------------------------------------------------
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      next_id_q <= dma_pkg::tf_id_t'(1);
      done_id_q <= '0;
    end else begin
      if (is_launch && launch_ready_i) begin
        next_id_q <= next_id_q + dma_pkg::tf_id_t'(1);
      end
      if (trans_done_i) begin
        done_id_q <= done_id_q + dma_pkg::tf_id_t'(1);
      end
    end
  end

  //--------------------------------------------------------------------------
  // read mux and registered response
  //--------------------------------------------------------------------------
  always_comb begin
    case (reg_off)
      dma_pkg::RegSrcAddr:   rdata = src_q;
      dma_pkg::RegDstAddr:   rdata = dst_q;
      dma_pkg::RegLength:    rdata = len_q;
      dma_pkg::RegSrcStride: rdata = src_stride_q;
      dma_pkg::RegDstStride: rdata = dst_stride_q;
      dma_pkg::RegReps:      rdata = reps_q;
      dma_pkg::RegNextId:    rdata = next_id_q;
      dma_pkg::RegDoneId:    rdata = done_id_q;
      dma_pkg::RegStatus:    rdata = {{($bits(dma_pkg::data_t)-1){1'b0}}, busy_i};
      default:               rdata = '0;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      r_valid_q <= 1'b0;
    end else begin
      r_valid_q <= gnt;
    end
  end

  // writes answer with zero data
  always_ff @(posedge clk_i) begin
    if (gnt) begin
      r_data_q <= cfg_req_i.we ? '0 : rdata;
    end
  end

  always_comb begin
    cfg_rsp_o.gnt     = gnt;
    cfg_rsp_o.r_valid = r_valid_q;
    cfg_rsp_o.r_data  = r_data_q;
  end

endmodule

`default_nettype wire

// File: verilog/dma_req_queue.sv
//--------------------------------------------------------------------------
// circular FIFO of launched transfers between the register frontend and
// the 2D midend; a pop frees a slot for a push in the same cycle
//--------------------------------------------------------------------------

`timescale 1ns/1ps
`default_nettype none

module dma_req_queue #(
  parameter int unsigned Depth = 2
) (
  input  logic             clk_i,
  input  logic             rst_n_i,
  input  logic             push_valid_i,
  input  dma_pkg::nd_req_t push_req_i,
  output logic             push_ready_o,
  output logic             pop_valid_o,
  output dma_pkg::nd_req_t pop_req_o,
  input  logic             pop_ready_i,
  output logic             empty_o
);

  localparam int unsigned PtrWidth = (Depth > 1) ? $clog2(Depth) : 1;
  localparam int unsigned CntWidth = $clog2(Depth + 1);
  localparam logic [PtrWidth-1:0] LastPtr = PtrWidth'(Depth - 1);
  localparam logic [CntWidth-1:0] FullCnt = CntWidth'(Depth);

  dma_pkg::nd_req_t    mem_q [Depth];
  logic [PtrWidth-1:0] wr_ptr_q, rd_ptr_q;
  logic [CntWidth-1:0] cnt_q;
  logic                push, pop;

  assign pop_valid_o  = (cnt_q != '0);
  assign empty_o      = (cnt_q == '0);
  assign pop          = pop_valid_o & pop_ready_i;
  // full, but the entry at the head leaves this cycle
  assign push_ready_o = (cnt_q != FullCnt) | pop;
  assign push         = push_valid_i & push_ready_o;
  assign pop_req_o    = mem_q[rd_ptr_q];

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      cnt_q    <= '0;
    end else begin
      if (push) begin
        wr_ptr_q <= (wr_ptr_q == LastPtr) ? '0 : wr_ptr_q + PtrWidth'(1);
      end
      if (pop) begin
        rd_ptr_q <= (rd_ptr_q == LastPtr) ? '0 : rd_ptr_q + PtrWidth'(1);
      end
      if (push && !pop) begin
        cnt_q <= cnt_q + CntWidth'(1);
      end else if (pop && !push) begin
        cnt_q <= cnt_q - CntWidth'(1);
      end
    end
  end

  // storage
  always_ff @(posedge clk_i) begin
    if (push) begin
      mem_q[wr_ptr_q] <= push_req_i;
    end
  end

endmodule

`default_nettype wire

// File: verilog/dma_wrap.sv
//--------------------------------------------------------------------------
// DMA front end top level: register frontend, request queue and 2D
// midend, with the completion event and the busy flag
//--------------------------------------------------------------------------

`timescale 1ns/1ps
`default_nettype none

module dma_wrap #(
  parameter int unsigned QueueDepth = 2
) (
  input  logic                clk_i,
  input  logic                rst_n_i,
  input  dma_pkg::cfg_req_t   cfg_req_i,
  output dma_pkg::cfg_rsp_t   cfg_rsp_o,
  output dma_pkg::burst_req_t burst_o,
  output logic                burst_valid_o,
  input  logic                burst_ready_i,
  input  logic                burst_rsp_valid_i,
  output logic                term_event_o,
  output logic                busy_o
);

  logic             launch_valid, launch_ready;
  dma_pkg::nd_req_t launch_req, queue_req;
  logic             queue_valid, queue_ready, queue_empty;
  logic             midend_idle, trans_done, term_event_q;

  dma_reg_frontend i_reg_frontend (
    .clk_i,
    .rst_n_i,
    .cfg_req_i,
    .cfg_rsp_o,
    .busy_i         (busy_o),
    .trans_done_i   (trans_done),
    .launch_valid_o (launch_valid),
    .launch_req_o   (launch_req),
    .launch_ready_i (launch_ready)
  );

  dma_req_queue #(
    .Depth (QueueDepth)
  ) i_req_queue (
    .clk_i,
    .rst_n_i,
    .push_valid_i (launch_valid),
    .push_req_i   (launch_req),
    .push_ready_o (launch_ready),
    .pop_valid_o  (queue_valid),
    .pop_req_o    (queue_req),
    .pop_ready_i  (queue_ready),
    .empty_o      (queue_empty)
  );

  dma_2d_midend i_2d_midend (
    .clk_i,
    .rst_n_i,
    .nd_valid_i        (queue_valid),
    .nd_req_i          (queue_req),
    .nd_ready_o        (queue_ready),
    .burst_o,
    .burst_valid_o,
    .burst_ready_i,
    .burst_rsp_valid_i,
    .trans_done_o      (trans_done),
    .idle_o            (midend_idle)
  );

  // completion event, one cycle after the last response
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      term_event_q <= 1'b0;
    end else begin
      term_event_q <= trans_done;
    end
  end

  assign term_event_o = term_event_q;
  assign busy_o       = ~queue_empty | ~midend_idle;

endmodule

`default_nettype wire
